// ==== verilog/axi_lite_pkg.sv ====
package axi_lite_pkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // response codes
    localparam logic [1:0] RESP_OKAY = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // address map
    localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h8000_0000;
    localparam logic [ADDR_W-1:0] MTIMER_BASE = 32'h0200_0000;
    // timer decode window, registers live in the first 16 bytes
    localparam logic [ADDR_W-1:0] MTIMER_SPAN = 32'h0000_1000;

    // master-driven signals
    typedef struct packed {
        logic [ADDR_W-1:0] araddr;
        logic arvalid;
        logic rready;
        logic [ADDR_W-1:0] awaddr;
        logic awvalid;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb;
        logic wvalid;
        logic bready;
    } axi_req_t;

    // slave-driven signals
    typedef struct packed {
        logic arready;
        logic [DATA_W-1:0] rdata;
        logic [1:0] rresp;
        logic rvalid;
        logic awready;
        logic wready;
        logic [1:0] bresp;
        logic bvalid;
    } axi_rsp_t;

    typedef enum logic {
        GRANT_FETCH,
        GRANT_LSU
    } grant_e;

    typedef enum logic [1:0] {
        ROUTE_SRAM,
        ROUTE_TIMER,
        ROUTE_ERR
    } route_e;

    typedef enum logic [1:0] {
        SRAM_IDLE,
        SRAM_RDATA,
        SRAM_BRESP
    } sram_state_e;

    // merge the strobed bytes of new_word into old_word
    function automatic logic [DATA_W-1:0] apply_strb(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [STRB_W-1:0] strb);
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int i = 0; i < STRB_W; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// ==== verilog/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_lite_pkg::axi_req_t fetch_req,
    output axi_lite_pkg::axi_rsp_t fetch_rsp,
    input  axi_lite_pkg::axi_req_t lsu_req,
    output axi_lite_pkg::axi_rsp_t lsu_rsp,
    output axi_lite_pkg::axi_req_t bus_req,
    input  axi_lite_pkg::axi_rsp_t bus_rsp
);

    axi_lite_pkg::grant_e grant;
    axi_lite_pkg::grant_e grant_next;
    logic rd_out;
    logic wr_out;
    logic idle;
    logic lsu_wants;
    logic to_lsu;
    logic to_fetch;
    logic rd_hs;
    logic r_hs;
    logic wr_hs;
    logic b_hs;

    // handshakes seen on the shared bus
    assign rd_hs = bus_req.arvalid && bus_rsp.arready;
    assign r_hs = bus_rsp.rvalid && bus_req.rready;
    assign wr_hs = bus_req.awvalid && bus_req.wvalid && bus_rsp.awready && bus_rsp.wready;
    assign b_hs = bus_rsp.bvalid && bus_req.bready;

    assign idle = !rd_out && !wr_out;
    assign lsu_wants = lsu_req.arvalid || lsu_req.awvalid;

    // lsu first, fetch only gets the bus back when lsu is quiet
    assign to_lsu = (grant == axi_lite_pkg::GRANT_FETCH) && idle && lsu_wants;
    assign to_fetch = (grant == axi_lite_pkg::GRANT_LSU) && idle && fetch_req.arvalid
                      && !lsu_wants;

    always_comb begin
        grant_next = grant;
        if (to_lsu) begin
            grant_next = axi_lite_pkg::GRANT_LSU;
        end else if (to_fetch) begin
            grant_next = axi_lite_pkg::GRANT_FETCH;
        end
    end

    // request steering, fetch never writes
    always_comb begin
        bus_req = '0;
        if (grant == axi_lite_pkg::GRANT_LSU) begin
            bus_req = lsu_req;
        end else begin
            bus_req.araddr = fetch_req.araddr;
            // hold fetch off in the cycle the grant leaves it
            bus_req.arvalid = fetch_req.arvalid && !to_lsu;
            bus_req.rready = fetch_req.rready;
        end
    end

    // responses go back to the granted master only
    always_comb begin
        fetch_rsp = '0;
        lsu_rsp = '0;
        if (grant == axi_lite_pkg::GRANT_LSU) begin
            lsu_rsp = bus_rsp;
        end else begin
            fetch_rsp.arready = bus_rsp.arready && !to_lsu;
            fetch_rsp.rdata = bus_rsp.rdata;
            fetch_rsp.rresp = bus_rsp.rresp;
            fetch_rsp.rvalid = bus_rsp.rvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            grant <= axi_lite_pkg::GRANT_FETCH;
            rd_out <= 1'b0;
            wr_out <= 1'b0;
        end else begin
            grant <= grant_next;
            if (rd_hs) begin
                rd_out <= 1'b1;
            end else if (r_hs) begin
                rd_out <= 1'b0;
            end
            if (wr_hs) begin
                wr_out <= 1'b1;
            end else if (b_hs) begin
                wr_out <= 1'b0;
            end
        end
    end

    // grant is frozen while a request is accepted or waits for its response
    a_grant_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rd_out || wr_out || rd_hs || wr_hs) |=> $stable(grant)
    );

endmodule

// ==== verilog/addr_xbar.sv ====
`timescale 1ns/1ps

module addr_xbar #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_lite_pkg::axi_req_t bus_req,
    output axi_lite_pkg::axi_rsp_t bus_rsp,
    output axi_lite_pkg::axi_req_t sram_req,
    input  axi_lite_pkg::axi_rsp_t sram_rsp,
    output axi_lite_pkg::axi_req_t timer_req,
    input  axi_lite_pkg::axi_rsp_t timer_rsp
);

    localparam logic [axi_lite_pkg::ADDR_W-1:0] SRAM_BYTES =
        axi_lite_pkg::ADDR_W'(SRAM_DEPTH * 4);

    axi_lite_pkg::route_e ar_route;
    axi_lite_pkg::route_e aw_route;
    axi_lite_pkg::route_e rd_route;
    axi_lite_pkg::route_e wr_route;
    axi_lite_pkg::axi_rsp_t rd_src;
    axi_lite_pkg::axi_rsp_t wr_src;
    logic rd_busy;
    logic wr_busy;
    logic rd_hs;
    logic r_hs;
    logic wr_hs;
    logic b_hs;

    function automatic axi_lite_pkg::route_e decode(input logic [axi_lite_pkg::ADDR_W-1:0] addr);
        logic [axi_lite_pkg::ADDR_W-1:0] sram_off;
        sram_off = addr - axi_lite_pkg::SRAM_BASE;
        // addresses below the base wrap to a large offset
        if (sram_off < SRAM_BYTES) begin
            return axi_lite_pkg::ROUTE_SRAM;
        end
        if ((addr & ~(axi_lite_pkg::MTIMER_SPAN - 1)) == axi_lite_pkg::MTIMER_BASE) begin
            return axi_lite_pkg::ROUTE_TIMER;
        end
        return axi_lite_pkg::ROUTE_ERR;
    endfunction

    assign ar_route = decode(bus_req.araddr);
    assign aw_route = decode(bus_req.awaddr);

    assign rd_hs = bus_req.arvalid && bus_rsp.arready;
    assign r_hs = bus_rsp.rvalid && bus_req.rready;
    assign wr_hs = bus_req.awvalid && bus_req.wvalid && bus_rsp.awready && bus_rsp.wready;
    assign b_hs = bus_rsp.bvalid && bus_req.bready;

    // payload goes to both slaves, only valids and readies are steered
    always_comb begin
        sram_req = bus_req;
        timer_req = bus_req;
        sram_req.arvalid = bus_req.arvalid && !rd_busy && ar_route == axi_lite_pkg::ROUTE_SRAM;
        timer_req.arvalid = bus_req.arvalid && !rd_busy && ar_route == axi_lite_pkg::ROUTE_TIMER;
        sram_req.rready = bus_req.rready && rd_busy && rd_route == axi_lite_pkg::ROUTE_SRAM;
        timer_req.rready = bus_req.rready && rd_busy && rd_route == axi_lite_pkg::ROUTE_TIMER;
        sram_req.awvalid = bus_req.awvalid && !wr_busy && aw_route == axi_lite_pkg::ROUTE_SRAM;
        timer_req.awvalid = bus_req.awvalid && !wr_busy && aw_route == axi_lite_pkg::ROUTE_TIMER;
        sram_req.wvalid = bus_req.wvalid && !wr_busy && aw_route == axi_lite_pkg::ROUTE_SRAM;
        timer_req.wvalid = bus_req.wvalid && !wr_busy && aw_route == axi_lite_pkg::ROUTE_TIMER;
        sram_req.bready = bus_req.bready && wr_busy && wr_route == axi_lite_pkg::ROUTE_SRAM;
        timer_req.bready = bus_req.bready && wr_busy && wr_route == axi_lite_pkg::ROUTE_TIMER;
    end

    // address-phase source follows the decoded address
    assign rd_src = (rd_busy ? rd_route : ar_route) == axi_lite_pkg::ROUTE_TIMER
                    ? timer_rsp : sram_rsp;
    assign wr_src = (wr_busy ? wr_route : aw_route) == axi_lite_pkg::ROUTE_TIMER
                    ? timer_rsp : sram_rsp;

    // readies only answer a valid, so an idle bus rests with all readies low
    always_comb begin
        bus_rsp = '0;
        if (!rd_busy) begin
            bus_rsp.arready = bus_req.arvalid
                              && ((ar_route == axi_lite_pkg::ROUTE_ERR) || rd_src.arready);
        end else if (rd_route == axi_lite_pkg::ROUTE_ERR) begin
            bus_rsp.rresp = axi_lite_pkg::RESP_DECERR;
            bus_rsp.rvalid = 1'b1;
        end else begin
            bus_rsp.rdata = rd_src.rdata;
            bus_rsp.rresp = rd_src.rresp;
            bus_rsp.rvalid = rd_src.rvalid;
        end
        if (!wr_busy) begin
            bus_rsp.awready = bus_req.awvalid && bus_req.wvalid
                              && ((aw_route == axi_lite_pkg::ROUTE_ERR) || wr_src.awready);
            bus_rsp.wready = bus_req.awvalid && bus_req.wvalid
                             && ((aw_route == axi_lite_pkg::ROUTE_ERR) || wr_src.wready);
        end else if (wr_route == axi_lite_pkg::ROUTE_ERR) begin
            bus_rsp.bresp = axi_lite_pkg::RESP_DECERR;
            bus_rsp.bvalid = 1'b1;
        end else begin
            bus_rsp.bresp = wr_src.bresp;
            bus_rsp.bvalid = wr_src.bvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_busy <= 1'b0;
            wr_busy <= 1'b0;
            rd_route <= axi_lite_pkg::ROUTE_ERR;
            wr_route <= axi_lite_pkg::ROUTE_ERR;
        end else begin
            if (rd_hs) begin
                rd_busy <= 1'b1;
                rd_route <= ar_route;
            end else if (r_hs) begin
                rd_busy <= 1'b0;
            end
            if (wr_hs) begin
                wr_busy <= 1'b1;
                wr_route <= aw_route;
            end else if (b_hs) begin
                wr_busy <= 1'b0;
            end
        end
    end

    // a slave only answers a read this crossbar routed to it
    a_sram_rvalid_routed: assert property (
        @(posedge clk) disable iff (!rst_n)
        sram_rsp.rvalid |-> rd_busy && rd_route == axi_lite_pkg::ROUTE_SRAM
    );
    a_timer_rvalid_routed: assert property (
        @(posedge clk) disable iff (!rst_n)
        timer_rsp.rvalid |-> rd_busy && rd_route == axi_lite_pkg::ROUTE_TIMER
    );

endmodule

// ==== verilog/sram_slave.sv ====
`timescale 1ns/1ps

module sram_slave #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_lite_pkg::axi_req_t req,
    output axi_lite_pkg::axi_rsp_t rsp
);

    localparam int IDX_W = $clog2(SRAM_DEPTH);

    axi_lite_pkg::sram_state_e state;
    logic [axi_lite_pkg::DATA_W-1:0] mem [SRAM_DEPTH];
    logic [axi_lite_pkg::DATA_W-1:0] rdata_q;
    logic [axi_lite_pkg::ADDR_W-1:0] ar_off;
    logic [axi_lite_pkg::ADDR_W-1:0] aw_off;
    logic [IDX_W-1:0] ar_idx;
    logic [IDX_W-1:0] aw_idx;
    logic wr_ready;
    logic rd_hs;
    logic wr_hs;

    // word index from the byte offset into the region
    assign ar_off = req.araddr - axi_lite_pkg::SRAM_BASE;
    assign aw_off = req.awaddr - axi_lite_pkg::SRAM_BASE;
    assign ar_idx = ar_off[IDX_W+1:2];
    assign aw_idx = aw_off[IDX_W+1:2];

    // reads win when both arrive together
    assign wr_ready = (state == axi_lite_pkg::SRAM_IDLE) && !req.arvalid;
    assign rd_hs = req.arvalid && (state == axi_lite_pkg::SRAM_IDLE);
    assign wr_hs = req.awvalid && req.wvalid && wr_ready;

    always_comb begin
        rsp = '0;
        rsp.arready = (state == axi_lite_pkg::SRAM_IDLE);
        rsp.rdata = rdata_q;
        rsp.rresp = axi_lite_pkg::RESP_OKAY;
        rsp.rvalid = (state == axi_lite_pkg::SRAM_RDATA);
        rsp.awready = wr_ready;
        rsp.wready = wr_ready;
        rsp.bresp = axi_lite_pkg::RESP_OKAY;
        rsp.bvalid = (state == axi_lite_pkg::SRAM_BRESP);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= axi_lite_pkg::SRAM_IDLE;
        end else begin
            case (state)
                axi_lite_pkg::SRAM_IDLE: begin
                    if (rd_hs) begin
                        state <= axi_lite_pkg::SRAM_RDATA;
                    end else if (wr_hs) begin
                        state <= axi_lite_pkg::SRAM_BRESP;
                    end
                end
                axi_lite_pkg::SRAM_RDATA: begin
                    if (req.rready) begin
                        state <= axi_lite_pkg::SRAM_IDLE;
                    end
                end
                axi_lite_pkg::SRAM_BRESP: begin
                    if (req.bready) begin
                        state <= axi_lite_pkg::SRAM_IDLE;
                    end
                end
                default: state <= axi_lite_pkg::SRAM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata_q <= mem[ar_idx];
        end
        if (wr_hs) begin
            mem[aw_idx] <= axi_lite_pkg::apply_strb(mem[aw_idx], req.wdata, req.wstrb);
        end
    end

    // read response held until the master takes it
    a_rdata_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata)
    );

endmodule

// ==== verilog/mtimer_slave.sv ====
`timescale 1ns/1ps

module mtimer_slave (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_lite_pkg::axi_req_t req,
    output axi_lite_pkg::axi_rsp_t rsp,
    output logic                   timer_irq
);

    localparam int OFF_W = $clog2(axi_lite_pkg::MTIMER_SPAN);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [axi_lite_pkg::DATA_W-1:0] rd_word;
    logic [axi_lite_pkg::DATA_W-1:0] rdata_q;
    logic [1:0] rresp_q;
    logic [1:0] bresp_q;
    logic [OFF_W-1:0] ar_off;
    logic [OFF_W-1:0] aw_off;
    logic rvalid_q;
    logic bvalid_q;
    logic wr_ready;
    logic rd_hs;
    logic wr_hs;
    logic rd_ok;
    logic wr_ok;

    assign ar_off = req.araddr[OFF_W-1:0];
    assign aw_off = req.awaddr[OFF_W-1:0];
    // only the four aligned words below 0x10 exist
    assign rd_ok = (ar_off[OFF_W-1:4] == '0) && (ar_off[1:0] == 2'b00);
    assign wr_ok = (aw_off[OFF_W-1:4] == '0) && (aw_off[1:0] == 2'b00);

    assign wr_ready = !rvalid_q && !bvalid_q && !req.arvalid;
    assign rd_hs = req.arvalid && !rvalid_q && !bvalid_q;
    assign wr_hs = req.awvalid && req.wvalid && wr_ready;

    always_comb begin
        case (ar_off[3:2])
            2'd0: rd_word = mtime[31:0];
            2'd1: rd_word = mtime[63:32];
            2'd2: rd_word = mtimecmp[31:0];
            default: rd_word = mtimecmp[63:32];
        endcase
    end

    always_comb begin
        rsp = '0;
        rsp.arready = !rvalid_q && !bvalid_q;
        rsp.rdata = rdata_q;
        rsp.rresp = rresp_q;
        rsp.rvalid = rvalid_q;
        rsp.awready = wr_ready;
        rsp.wready = wr_ready;
        rsp.bresp = bresp_q;
        rsp.bvalid = bvalid_q;
    end

    // a write to mtime replaces that half and skips the increment
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime <= '0;
            mtimecmp <= '1;
        end else begin
            mtime <= mtime + 64'd1;
            if (wr_hs && wr_ok) begin
                case (aw_off[3:2])
                    2'd0: mtime[31:0] <= axi_lite_pkg::apply_strb(mtime[31:0], req.wdata,
                                                                 req.wstrb);
                    2'd1: mtime[63:32] <= axi_lite_pkg::apply_strb(mtime[63:32], req.wdata,
                                                                  req.wstrb);
                    2'd2: mtimecmp[31:0] <= axi_lite_pkg::apply_strb(mtimecmp[31:0], req.wdata,
                                                                    req.wstrb);
                    default: mtimecmp[63:32] <= axi_lite_pkg::apply_strb(mtimecmp[63:32],
                                                                        req.wdata, req.wstrb);
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= (mtime >= mtimecmp);
            if (rd_hs) begin
                rvalid_q <= 1'b1;
            end else if (req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (wr_hs) begin
                bvalid_q <= 1'b1;
            end else if (req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata_q <= rd_ok ? rd_word : '0;
            rresp_q <= rd_ok ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
        end
        if (wr_hs) begin
            bresp_q <= wr_ok ? axi_lite_pkg::RESP_OKAY : axi_lite_pkg::RESP_SLVERR;
        end
    end

endmodule

// ==== verilog/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int SRAM_DEPTH = 256
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  axi_lite_pkg::axi_req_t fetch_req,
    output axi_lite_pkg::axi_rsp_t fetch_rsp,
    input  axi_lite_pkg::axi_req_t lsu_req,
    output axi_lite_pkg::axi_rsp_t lsu_rsp,
    output logic                   timer_irq
);

    // shared bus between arbiter and crossbar
    axi_lite_pkg::axi_req_t bus_req;
    axi_lite_pkg::axi_rsp_t bus_rsp;
    // crossbar to slaves
    axi_lite_pkg::axi_req_t sram_req;
    axi_lite_pkg::axi_rsp_t sram_rsp;
    axi_lite_pkg::axi_req_t timer_req;
    axi_lite_pkg::axi_rsp_t timer_rsp;

    bus_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (fetch_req),
        .fetch_rsp (fetch_rsp),
        .lsu_req   (lsu_req),
        .lsu_rsp   (lsu_rsp),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp)
    );

    addr_xbar #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) u_xbar (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .sram_req  (sram_req),
        .sram_rsp  (sram_rsp),
        .timer_req (timer_req),
        .timer_rsp (timer_rsp)
    );

    sram_slave #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) u_sram (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (sram_req),
        .rsp   (sram_rsp)
    );

    mtimer_slave u_mtimer (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (timer_req),
        .rsp       (timer_rsp),
        .timer_irq (timer_irq)
    );

endmodule

// ==== sim/tb_mem_subsys.sv ====
`timescale 1ns/1ps

module tb_mem_subsys;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 4;
    localparam int SRAM_DEPTH = 256;
    localparam int SEED = 9191;
    localparam int CYCLES_PER_ENTRY = 20;
    localparam int MAX_IRQ_WAIT = 20;
    localparam logic PORT_FETCH = 1'b0;
    localparam logic PORT_LSU = 1'b1;
    localparam logic [31:0] SRAM_A0 = axi_lite_pkg::SRAM_BASE + 32'h10;
    localparam logic [31:0] SRAM_A1 = axi_lite_pkg::SRAM_BASE + 32'h20;
    localparam logic [31:0] SRAM_LAST = axi_lite_pkg::SRAM_BASE + 32'((SRAM_DEPTH - 1) * 4);
    localparam logic [31:0] SRAM_BEYOND = axi_lite_pkg::SRAM_BASE + 32'(SRAM_DEPTH * 4);
    localparam logic [31:0] TMR = axi_lite_pkg::MTIMER_BASE;

    typedef enum logic [2:0] {
        OP_READ,
        OP_WRITE,
        OP_DUAL_READ,
        OP_MTIME_RUN,
        OP_TIMER_IRQ
    } op_e;

    // addr2 and exp_data2 are the fetch side of a dual read
    typedef struct packed {
        logic port;
        op_e op;
        logic [31:0] addr;
        logic [31:0] addr2;
        logic [31:0] wdata;
        logic [3:0] wstrb;
        logic [31:0] exp_data;
        logic [31:0] exp_data2;
        logic [1:0] exp_resp;
        logic chk_data;
    } entry_t;

    logic clk;
    logic rst_n;
    axi_lite_pkg::axi_req_t [1:0] req_drv;
    axi_lite_pkg::axi_rsp_t fetch_rsp;
    axi_lite_pkg::axi_rsp_t lsu_rsp;
    logic timer_irq;
    logic [1:0] rd_wait;
    entry_t tbl [$];
    logic [31:0] shadow [logic [31:0]];
    int n_entries;

    mem_subsys_top #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .fetch_req (req_drv[PORT_FETCH]),
        .fetch_rsp (fetch_rsp),
        .lsu_req   (req_drv[PORT_LSU]),
        .lsu_rsp   (lsu_rsp),
        .timer_irq (timer_irq)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR at time %0t: %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic axi_lite_pkg::axi_rsp_t rsp_of(input logic port);
        return port ? lsu_rsp : fetch_rsp;
    endfunction

    // byte-lane model of a strobed write
    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0] strb);
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic add_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] resp);
        entry_t e;
        logic [31:0] old_word;
        e = '0;
        e.port = PORT_LSU;
        e.op = OP_WRITE;
        e.addr = addr;
        e.wdata = data;
        e.wstrb = strb;
        e.exp_resp = resp;
        if (resp == axi_lite_pkg::RESP_OKAY) begin
            old_word = shadow.exists(addr) ? shadow[addr] : 32'h0;
            shadow[addr] = merge_bytes(old_word, data, strb);
        end
        tbl.push_back(e);
    endtask

    task automatic add_read(input logic port, input logic [31:0] addr,
                            input logic [1:0] resp, input logic chk_data);
        entry_t e;
        e = '0;
        e.port = port;
        e.op = OP_READ;
        e.addr = addr;
        e.exp_resp = resp;
        e.chk_data = chk_data;
        // error responses carry zero data
        if (resp == axi_lite_pkg::RESP_OKAY && chk_data) begin
            e.exp_data = shadow[addr];
        end
        tbl.push_back(e);
    endtask

    task automatic add_dual(input logic [31:0] lsu_addr, input logic [31:0] fetch_addr);
        entry_t e;
        e = '0;
        e.port = PORT_LSU;
        e.op = OP_DUAL_READ;
        e.addr = lsu_addr;
        e.addr2 = fetch_addr;
        e.exp_data = shadow[lsu_addr];
        e.exp_data2 = shadow[fetch_addr];
        tbl.push_back(e);
    endtask

    task automatic add_op(input op_e op);
        entry_t e;
        e = '0;
        e.port = PORT_LSU;
        e.op = op;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        add_write(SRAM_A0, $urandom(), 4'hF, axi_lite_pkg::RESP_OKAY);
        add_read(PORT_LSU, SRAM_A0, axi_lite_pkg::RESP_OKAY, 1'b1);
        add_write(SRAM_A0, $urandom(), 4'b0101, axi_lite_pkg::RESP_OKAY);
        add_read(PORT_LSU, SRAM_A0, axi_lite_pkg::RESP_OKAY, 1'b1);
        add_read(PORT_FETCH, SRAM_A0, axi_lite_pkg::RESP_OKAY, 1'b1);
        add_write(SRAM_A1, $urandom(), 4'hF, axi_lite_pkg::RESP_OKAY);
        add_write(SRAM_LAST, $urandom(), 4'hF, axi_lite_pkg::RESP_OKAY);
        add_write(SRAM_LAST, $urandom(), 4'b1000, axi_lite_pkg::RESP_OKAY);
        // both masters in the same cycle
        add_dual(SRAM_LAST, SRAM_A1);
        add_dual(SRAM_A1, SRAM_A0);
        add_dual(SRAM_A0, SRAM_LAST);
        // unmapped and past the end of the sram
        add_read(PORT_LSU, 32'h1000_0000, axi_lite_pkg::RESP_DECERR, 1'b1);
        add_write(32'h1000_0000, $urandom(), 4'hF, axi_lite_pkg::RESP_DECERR);
        add_read(PORT_LSU, SRAM_BEYOND, axi_lite_pkg::RESP_DECERR, 1'b1);
        add_write(SRAM_BEYOND, $urandom(), 4'hF, axi_lite_pkg::RESP_DECERR);
        add_read(PORT_FETCH, TMR + 32'h1000, axi_lite_pkg::RESP_DECERR, 1'b1);
        // mtimecmp, high half kept huge so the irq stays low
        add_write(TMR + 32'h8, $urandom(), 4'hF, axi_lite_pkg::RESP_OKAY);
        add_write(TMR + 32'hC, $urandom() | 32'h8000_0000, 4'hF, axi_lite_pkg::RESP_OKAY);
        add_read(PORT_LSU, TMR + 32'h8, axi_lite_pkg::RESP_OKAY, 1'b1);
        add_read(PORT_LSU, TMR + 32'hC, axi_lite_pkg::RESP_OKAY, 1'b1);
        add_op(OP_MTIME_RUN);
        add_read(PORT_LSU, TMR + 32'h10, axi_lite_pkg::RESP_SLVERR, 1'b0);
        add_op(OP_TIMER_IRQ);
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic do_read(input logic port, input logic [31:0] addr, input int stall,
                           output logic [31:0] data, output logic [1:0] resp,
                           output time done_at);
        axi_lite_pkg::axi_rsp_t r;
        logic seen;
        rd_wait[port] = 1'b1;
        req_drv[port].araddr = addr;
        req_drv[port].arvalid = 1'b1;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            r = rsp_of(port);
            seen = r.arready;
            @(negedge clk);
        end
        req_drv[port].arvalid = 1'b0;
        repeat (stall) @(negedge clk);
        req_drv[port].rready = 1'b1;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            r = rsp_of(port);
            seen = r.rvalid;
            @(negedge clk);
        end
        req_drv[port].rready = 1'b0;
        rd_wait[port] = 1'b0;
        data = r.rdata;
        resp = r.rresp;
        done_at = $time;
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int stall, output logic [1:0] resp);
        logic seen;
        req_drv[PORT_LSU].awaddr = addr;
        req_drv[PORT_LSU].wdata = data;
        req_drv[PORT_LSU].wstrb = strb;
        req_drv[PORT_LSU].awvalid = 1'b1;
        req_drv[PORT_LSU].wvalid = 1'b1;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            seen = lsu_rsp.awready && lsu_rsp.wready;
            @(negedge clk);
        end
        req_drv[PORT_LSU].awvalid = 1'b0;
        req_drv[PORT_LSU].wvalid = 1'b0;
        repeat (stall) @(negedge clk);
        req_drv[PORT_LSU].bready = 1'b1;
        seen = 1'b0;
        while (!seen) begin
            @(posedge clk);
            seen = lsu_rsp.bvalid;
            resp = lsu_rsp.bresp;
            @(negedge clk);
        end
        req_drv[PORT_LSU].bready = 1'b0;
    endtask

    task automatic run_irq();
        logic [31:0] mtime_now;
        logic [1:0] resp;
        time done_at;
        int waited;
        // low half parked at all ones before the high half drops to zero
        do_write(TMR + 32'h8, 32'hFFFF_FFFF, 4'hF, 0, resp);
        check("lsu_rsp.bresp", 32'(resp), 32'(axi_lite_pkg::RESP_OKAY));
        do_write(TMR + 32'hC, 32'h0, 4'hF, 0, resp);
        check("lsu_rsp.bresp", 32'(resp), 32'(axi_lite_pkg::RESP_OKAY));
        do_read(PORT_LSU, TMR, 0, mtime_now, resp, done_at);
        check("timer_irq", 32'(timer_irq), 32'd0);
        do_write(TMR + 32'h8, mtime_now + 32'd8, 4'hF, 0, resp);
        check("lsu_rsp.bresp", 32'(resp), 32'(axi_lite_pkg::RESP_OKAY));
        waited = 0;
        while (timer_irq !== 1'b1 && waited < MAX_IRQ_WAIT) begin
            @(negedge clk);
            waited++;
        end
        check("timer_irq", 32'(timer_irq), 32'd1);
        repeat (8) begin
            @(negedge clk);
            check("timer_irq", 32'(timer_irq), 32'd1);
        end
    endtask

    task automatic run_entry(input entry_t e);
        logic [31:0] data_a;
        logic [31:0] data_b;
        logic [1:0] resp_a;
        logic [1:0] resp_b;
        time t_a;
        time t_b;
        int stall_a;
        int stall_b;
        string pname;
        stall_a = $urandom_range(3, 0);
        stall_b = $urandom_range(3, 0);
        pname = e.port ? "lsu_rsp" : "fetch_rsp";
        case (e.op)
            OP_READ: begin
                do_read(e.port, e.addr, stall_a, data_a, resp_a, t_a);
                check({pname, ".rresp"}, 32'(resp_a), 32'(e.exp_resp));
                if (e.chk_data) begin
                    check({pname, ".rdata"}, data_a, e.exp_data);
                end
            end
            OP_WRITE: begin
                do_write(e.addr, e.wdata, e.wstrb, stall_a, resp_a);
                check("lsu_rsp.bresp", 32'(resp_a), 32'(e.exp_resp));
            end
            OP_DUAL_READ: begin
                fork
                    do_read(PORT_LSU, e.addr, stall_a, data_a, resp_a, t_a);
                    do_read(PORT_FETCH, e.addr2, stall_b, data_b, resp_b, t_b);
                join
                check("lsu_rsp.rresp", 32'(resp_a), 32'(axi_lite_pkg::RESP_OKAY));
                check("lsu_rsp.rdata", data_a, e.exp_data);
                check("fetch_rsp.rresp", 32'(resp_b), 32'(axi_lite_pkg::RESP_OKAY));
                check("fetch_rsp.rdata", data_b, e.exp_data2);
                check("lsu response before fetch", 32'(t_a < t_b), 32'd1);
            end
            OP_MTIME_RUN: begin
                do_read(PORT_LSU, TMR, stall_a, data_a, resp_a, t_a);
                do_read(PORT_LSU, TMR, stall_b, data_b, resp_b, t_b);
                check("lsu_rsp.rresp", 32'(resp_a), 32'(axi_lite_pkg::RESP_OKAY));
                check("lsu_rsp.rresp", 32'(resp_b), 32'(axi_lite_pkg::RESP_OKAY));
                check("mtime low increasing", 32'(data_b > data_a), 32'd1);
            end
            default: run_irq();
        endcase
    endtask

    // fetch has no write path, and sees nothing while lsu waits on a read
    always @(posedge clk) begin
        if (rst_n) begin
            check("fetch_rsp.awready", 32'(fetch_rsp.awready), 32'd0);
            check("fetch_rsp.wready", 32'(fetch_rsp.wready), 32'd0);
            check("fetch_rsp.bvalid", 32'(fetch_rsp.bvalid), 32'd0);
            check("fetch_rsp.bresp", 32'(fetch_rsp.bresp), 32'd0);
            if (rd_wait[PORT_LSU]) begin
                check("fetch_rsp.rvalid", 32'(fetch_rsp.rvalid), 32'd0);
            end
        end
    end

    initial begin
        wait (n_entries > 0);
        #((RESET_CYCLES + n_entries * CYCLES_PER_ENTRY) * CLK_PERIOD);
        $display("ERROR: watchdog expired at time %0t, the run hung waiting on the bus", $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        req_drv = '0;
        rd_wait = '0;
        n_entries = 0;
        build_table();
        n_entries = tbl.size();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // reset state
        check("fetch_rsp.arready", 32'(fetch_rsp.arready), 32'd0);
        check("fetch_rsp.rvalid", 32'(fetch_rsp.rvalid), 32'd0);
        check("fetch_rsp.bvalid", 32'(fetch_rsp.bvalid), 32'd0);
        check("lsu_rsp.arready", 32'(lsu_rsp.arready), 32'd0);
        check("lsu_rsp.rvalid", 32'(lsu_rsp.rvalid), 32'd0);
        check("lsu_rsp.awready", 32'(lsu_rsp.awready), 32'd0);
        check("lsu_rsp.wready", 32'(lsu_rsp.wready), 32'd0);
        check("lsu_rsp.bvalid", 32'(lsu_rsp.bvalid), 32'd0);
        check("timer_irq", 32'(timer_irq), 32'd0);
        foreach (tbl[i]) begin
            run_entry(tbl[i]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== all.f ====
verilog/axi_lite_pkg.sv
verilog/bus_arbiter.sv
verilog/addr_xbar.sv
verilog/sram_slave.sv
verilog/mtimer_slave.sv
verilog/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --timing --assert --timescale 1ns/1ps
TOP      := tb_mem_subsys
FILELIST := all.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
